/* files.f */
+incdir+.
hmr_pkg.sv
hmr_tmr_voter.sv
hmr_tmr_group.sv
hmr_cfg_regs.sv
hmr_mode_fsm.sv
hmr_core_mux.sv
hmr_wrap.sv
tb_hmr_wrap.sv

/* hmr_cfg_regs.sv */
// Per-group mode, scratch and mismatch counter registers with read mux
`include "hmr_settings.svh"

module hmr_cfg_regs (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         cfg_we_i,
  input  hmr_pkg::cfg_addr_t                           cfg_addr_i,
  input  hmr_pkg::word_t                               cfg_wdata_i,
  output hmr_pkg::word_t                               cfg_rdata_o,
  input  hmr_pkg::tmr_mode_e [`HMR_NUM_GROUPS-1:0]     mode_i,
  input  hmr_pkg::vote_err_t [`HMR_NUM_GROUPS-1:0]     count_i,
  input  logic               [`HMR_NUM_GROUPS-1:0]     force_clr_i,
  output logic               [`HMR_NUM_GROUPS-1:0]     independent_o,
  output logic               [`HMR_NUM_GROUPS-1:0]     setback_en_o,
  output logic               [`HMR_NUM_GROUPS-1:0]     reload_setback_en_o,
  output logic               [`HMR_NUM_GROUPS-1:0]     force_resynch_o,
  output hmr_pkg::word_t     [`HMR_NUM_GROUPS-1:0]     sp_store_o
);

  import hmr_pkg::*;

  localparam int unsigned G = `HMR_NUM_GROUPS;
  localparam int unsigned GrpSelW = `HMR_CFG_ADDR_W - `HMR_CFG_REG_W;

  // Mode bits: 0 independent, 1 setback, 2 reload setback, 3 force resynch
  logic          [G-1:0][3:0] mode_q;
  word_t         [G-1:0]      sp_store_q;
  mismatch_cnt_t [G-1:0][2:0] cnt_q;

  logic [GrpSelW-1:0]        grp_sel;
  logic [`HMR_CFG_REG_W-1:0] reg_sel;

  assign grp_sel = cfg_addr_i[`HMR_CFG_ADDR_W-1:`HMR_CFG_REG_W];
  assign reg_sel = cfg_addr_i[`HMR_CFG_REG_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= '0;
      sp_store_q <= '0;
      cnt_q      <= '0;
    end else begin
      for (int g = 0; g < G; g++) begin
        // FSM took the request
        if (force_clr_i[g]) begin
          mode_q[g][3] <= 1'b0;
        end
        if (cfg_we_i && (int'(grp_sel) == g)) begin
          if (reg_sel == `HMR_REG_MODE) begin
            mode_q[g] <= cfg_wdata_i[3:0];
          end
          if (reg_sel == `HMR_REG_SP_STORE) begin
            sp_store_q[g] <= cfg_wdata_i;
          end
        end
        // Saturating mismatch counters
        for (int k = 0; k < 3; k++) begin
          if (count_i[g][k] && (cnt_q[g][k] != '1)) begin
            cnt_q[g][k] <= cnt_q[g][k] + 1'b1;
          end
        end
      end
    end
  end

  for (genvar g = 0; g < G; g++) begin : gen_grp_out
    assign independent_o[g]       = mode_q[g][0];
    assign setback_en_o[g]        = mode_q[g][1];
    assign reload_setback_en_o[g] = mode_q[g][2];
    assign force_resynch_o[g]     = mode_q[g][3];
    assign sp_store_o[g]          = sp_store_q[g];
  end

  always_comb begin
    cfg_rdata_o = '0;
    if (int'(grp_sel) < G) begin
      case (reg_sel)
        `HMR_REG_MODE:      cfg_rdata_o = word_t'(mode_q[grp_sel]);
        `HMR_REG_SP_STORE:  cfg_rdata_o = sp_store_q[grp_sel];
        `HMR_REG_MISMATCH0: cfg_rdata_o = word_t'(cnt_q[grp_sel][0]);
        `HMR_REG_MISMATCH1: cfg_rdata_o = word_t'(cnt_q[grp_sel][1]);
        `HMR_REG_MISMATCH2: cfg_rdata_o = word_t'(cnt_q[grp_sel][2]);
        `HMR_REG_STATUS:    cfg_rdata_o = word_t'(mode_i[grp_sel]);
        default:            cfg_rdata_o = '0;
      endcase
    end
  end

  // Software only writes the mode and scratch registers of existing groups
  cfg_write_target_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cfg_we_i |-> (int'(grp_sel) < G) &&
                 ((reg_sel == `HMR_REG_MODE) || (reg_sel == `HMR_REG_SP_STORE))
  );

endmodule

/* hmr_core_mux.sv */
// Mode-dependent routing between system ports and core ports
`include "hmr_settings.svh"

module hmr_core_mux (
  input  hmr_pkg::tmr_mode_e  [`HMR_NUM_GROUPS-1:0] mode_i,
  input  hmr_pkg::sys_in_t    [`HMR_NUM_CORES-1:0]  sys_in_i,
  input  hmr_pkg::core_ctrl_t [`HMR_NUM_CORES-1:0]  core_ctrl_i,
  input  hmr_pkg::core_data_t [`HMR_NUM_CORES-1:0]  core_data_i,
  input  hmr_pkg::core_ctrl_t [`HMR_NUM_GROUPS-1:0] voted_ctrl_i,
  input  hmr_pkg::core_data_t [`HMR_NUM_GROUPS-1:0] voted_data_i,
  output hmr_pkg::sys_in_t    [`HMR_NUM_CORES-1:0]  core_in_o,
  output hmr_pkg::core_ctrl_t [`HMR_NUM_CORES-1:0]  sys_ctrl_o,
  output hmr_pkg::core_data_t [`HMR_NUM_CORES-1:0]  sys_data_o
);

  import hmr_pkg::*;

  localparam int unsigned G = `HMR_NUM_GROUPS;

  for (genvar i = 0; i < `HMR_NUM_CORES; i++) begin : gen_route
    // Interleaved grouping, core i belongs to group i mod G
    localparam int unsigned Grp = i % G;

    logic tmr_active;

    assign tmr_active = (mode_i[Grp] != NON_TMR);

    // All three replicas see the group's system port
    assign core_in_o[i] = tmr_active ? sys_in_i[Grp] : sys_in_i[i];

    if (i < G) begin : gen_voted_port
      assign sys_ctrl_o[i] = tmr_active ? voted_ctrl_i[i] : core_ctrl_i[i];
      assign sys_data_o[i] = tmr_active ? voted_data_i[i] : core_data_i[i];
    end else begin : gen_spare_port
      // Silent while the core runs as a replica
      assign sys_ctrl_o[i] = tmr_active ? core_ctrl_t'('0) : core_ctrl_i[i];
      assign sys_data_o[i] = tmr_active ? core_data_t'('0) : core_data_i[i];
    end
  end

endmodule

/* hmr_mode_fsm.sv */
// Per-group redundancy mode FSM with setback pulse, count and force-clear strobes
module hmr_mode_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  hmr_pkg::vote_err_t  error_i,
  input  logic                failure_i,
  input  logic                fetch_en_i,
  input  logic                busy_i,
  input  logic                cores_synch_i,
  input  logic                independent_i,
  input  logic                setback_en_i,
  input  logic                reload_setback_en_i,
  input  logic                force_resynch_i,
  input  hmr_pkg::word_t      sp_store_i,
  output hmr_pkg::tmr_mode_e  mode_o,
  output hmr_pkg::vote_err_t  count_o,
  output logic                force_clr_o,
  output logic                setback_o
);

  import hmr_pkg::*;

  tmr_mode_e mode_d;
  tmr_mode_e mode_q;
  logic      setback_d;
  logic      setback_q;

  // Later checks override earlier ones
  always_comb begin
    mode_d      = mode_q;
    setback_d   = 1'b0;
    count_o     = '0;
    force_clr_o = 1'b0;

    // Software requested resynch
    if (mode_q == TMR_RUN && force_resynch_i) begin
      mode_d      = TMR_UNLOAD;
      force_clr_o = 1'b1;
    end

    // Mismatch seen while running
    if (mode_q == TMR_RUN && error_i != '0) begin
      mode_d  = TMR_UNLOAD;
      count_o = error_i;
    end

    // State saved by software
    if (mode_q == TMR_UNLOAD && sp_store_i != '0) begin
      mode_d    = TMR_RELOAD;
      setback_d = setback_en_i;
    end

    if (mode_q == TMR_RELOAD) begin
      if (sp_store_i == '0) begin
        mode_d = TMR_RUN;
      end else if ((error_i != '0 || failure_i) && setback_en_i && reload_setback_en_i) begin
        setback_d = 1'b1;
      end
    end

    // Idle cores pick up the configured mode
    if (!fetch_en_i && !busy_i) begin
      mode_d = independent_i ? NON_TMR : TMR_RUN;
    end

    // Split off at any time
    if (mode_q == TMR_RUN && independent_i) begin
      mode_d = NON_TMR;
    end

    // Rejoin once the cores report they are in step
    if (mode_q == NON_TMR && cores_synch_i && !independent_i) begin
      mode_d = TMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= NON_TMR;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign mode_o    = mode_q;
  assign setback_o = setback_q;

  // Setback only comes out of the resynch sequence
  setback_in_resynch_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(setback_o) |-> $past(mode_q) inside {TMR_UNLOAD, TMR_RELOAD}
  );

endmodule

/* hmr_pkg.sv */
// Width typedefs, core and system bundle structs and the redundancy mode enum
`include "hmr_settings.svh"

package hmr_pkg;

  typedef logic [`HMR_ADDR_W-1:0] addr_t;
  typedef logic [`HMR_DATA_W-1:0] word_t;
  typedef logic [`HMR_BE_W-1:0] be_t;

  // One flag per core of a group
  typedef logic [2:0] vote_err_t;

  typedef logic [`HMR_CNT_W-1:0] mismatch_cnt_t;
  typedef logic [`HMR_CFG_ADDR_W-1:0] cfg_addr_t;

  // Control outputs of a core
  typedef struct packed {
    logic  busy;
    logic  instr_req;
    addr_t instr_addr;
    logic  data_req;
  } core_ctrl_t;

  // Data request of a core
  typedef struct packed {
    addr_t data_addr;
    logic  data_we;
    word_t data_wdata;
    be_t   data_be;
  } core_data_t;

  // System to core direction
  typedef struct packed {
    logic  fetch_en;
    addr_t boot_addr;
    logic  instr_gnt;
    logic  instr_rvalid;
    word_t instr_rdata;
    logic  data_gnt;
    logic  data_rvalid;
    word_t data_rdata;
  } sys_in_t;

  typedef enum logic [1:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD
  } tmr_mode_e;

endpackage

/* hmr_settings.svh */
// Group count, core count, bus widths and configuration register map
`ifndef HMR_SETTINGS_SVH
`define HMR_SETTINGS_SVH

// Interleaved TMR groups, three cores each
`define HMR_NUM_GROUPS 1
`define HMR_NUM_CORES (3 * `HMR_NUM_GROUPS)

// Core bus widths
`define HMR_ADDR_W 32
`define HMR_DATA_W 32
`define HMR_BE_W 4

// Per-core mismatch counter
`define HMR_CNT_W 8

// Config address, upper bits pick the group, lower bits the register
`define HMR_CFG_ADDR_W 5
`define HMR_CFG_REG_W 3

// Register offsets within a group
`define HMR_REG_MODE 0
`define HMR_REG_SP_STORE 1
`define HMR_REG_MISMATCH0 2
`define HMR_REG_MISMATCH1 3
`define HMR_REG_MISMATCH2 4
`define HMR_REG_STATUS 5

`endif

/* hmr_tmr_group.sv */
// Control and data voting for one TMR group with gated error merging
module hmr_tmr_group (
  input  hmr_pkg::core_ctrl_t [2:0] ctrl_i,
  input  hmr_pkg::core_data_t [2:0] data_i,
  output hmr_pkg::core_ctrl_t       ctrl_o,
  output hmr_pkg::core_data_t       data_o,
  output hmr_pkg::vote_err_t        error_o,
  output logic                      failure_o
);

  import hmr_pkg::*;

  vote_err_t ctrl_err;
  vote_err_t data_err;
  logic      ctrl_fail;
  logic      data_fail;
  logic      data_valid;
  logic      multi_err;

  hmr_tmr_voter #(
    .WIDTH ($bits(core_ctrl_t))
  ) i_ctrl_voter (
    .a_i        (ctrl_i[0]),
    .b_i        (ctrl_i[1]),
    .c_i        (ctrl_i[2]),
    .majority_o (ctrl_o),
    .error_o    (ctrl_err),
    .failure_o  (ctrl_fail)
  );

  hmr_tmr_voter #(
    .WIDTH ($bits(core_data_t))
  ) i_data_voter (
    .a_i        (data_i[0]),
    .b_i        (data_i[1]),
    .c_i        (data_i[2]),
    .majority_o (data_o),
    .error_o    (data_err),
    .failure_o  (data_fail)
  );

  // Data bundle only matters while a request is out
  assign data_valid = ctrl_o.data_req;

  assign error_o = data_valid ? (ctrl_err | data_err) : ctrl_err;

  // Cores wrong in different bundles also leave no clean core
  assign multi_err = (error_o[0] & error_o[1]) |
                     (error_o[0] & error_o[2]) |
                     (error_o[1] & error_o[2]);

  assign failure_o = ctrl_fail | (data_valid & data_fail) | multi_err;

endmodule

/* hmr_tmr_voter.sv */
// Bitwise three-input majority voter with per-input error flags and failure flag
module hmr_tmr_voter #(
  parameter int unsigned WIDTH = 1
) (
  input  logic [WIDTH-1:0]   a_i,
  input  logic [WIDTH-1:0]   b_i,
  input  logic [WIDTH-1:0]   c_i,
  output logic [WIDTH-1:0]   majority_o,
  output hmr_pkg::vote_err_t error_o,
  output logic               failure_o
);

  logic [WIDTH-1:0] diff_a;
  logic [WIDTH-1:0] diff_b;
  logic [WIDTH-1:0] diff_c;

  // Two out of three, per bit
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  assign diff_a = a_i ^ majority_o;
  assign diff_b = b_i ^ majority_o;
  assign diff_c = c_i ^ majority_o;

  // Bit k set when input k is off anywhere
  assign error_o[0] = |diff_a;
  assign error_o[1] = |diff_b;
  assign error_o[2] = |diff_c;

  // Two or more inputs off the majority word
  assign failure_o = (error_o[0] & error_o[1]) |
                     (error_o[0] & error_o[2]) |
                     (error_o[1] & error_o[2]);

  // Failure exactly when no two inputs agree
  failure_no_pair_a : assert final (
    failure_o == ((a_i != b_i) && (a_i != c_i) && (b_i != c_i))
  );

endmodule

/* hmr_wrap.sv */
// TMR wrapper top level with voters, mode FSMs, config registers and routing
`include "hmr_settings.svh"

module hmr_wrap (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       cfg_we_i,
  input  hmr_pkg::cfg_addr_t                         cfg_addr_i,
  input  hmr_pkg::word_t                             cfg_wdata_i,
  output hmr_pkg::word_t                             cfg_rdata_o,
  input  logic                [`HMR_NUM_GROUPS-1:0]  tmr_cores_synch_i,
  output hmr_pkg::vote_err_t  [`HMR_NUM_GROUPS-1:0]  tmr_error_o,
  output logic                [`HMR_NUM_GROUPS-1:0]  tmr_failure_o,
  input  hmr_pkg::sys_in_t    [`HMR_NUM_CORES-1:0]   sys_in_i,
  input  hmr_pkg::core_ctrl_t [`HMR_NUM_CORES-1:0]   core_ctrl_i,
  input  hmr_pkg::core_data_t [`HMR_NUM_CORES-1:0]   core_data_i,
  output hmr_pkg::sys_in_t    [`HMR_NUM_CORES-1:0]   core_in_o,
  output hmr_pkg::core_ctrl_t [`HMR_NUM_CORES-1:0]   sys_ctrl_o,
  output hmr_pkg::core_data_t [`HMR_NUM_CORES-1:0]   sys_data_o,
  output logic                [`HMR_NUM_CORES-1:0]   core_setback_o
);

  import hmr_pkg::*;

  localparam int unsigned G = `HMR_NUM_GROUPS;

  tmr_mode_e  [G-1:0] mode;
  vote_err_t  [G-1:0] count;
  word_t      [G-1:0] sp_store;
  core_ctrl_t [G-1:0] voted_ctrl;
  core_data_t [G-1:0] voted_data;
  logic       [G-1:0] force_clr;
  logic       [G-1:0] independent;
  logic       [G-1:0] setback_en;
  logic       [G-1:0] reload_setback_en;
  logic       [G-1:0] force_resynch;
  logic       [G-1:0] setback;

  for (genvar g = 0; g < G; g++) begin : gen_group
    // Replicas a, b, c are cores g, g+G, g+2G
    hmr_tmr_group i_group (
      .ctrl_i    ({core_ctrl_i[g+2*G], core_ctrl_i[g+G], core_ctrl_i[g]}),
      .data_i    ({core_data_i[g+2*G], core_data_i[g+G], core_data_i[g]}),
      .ctrl_o    (voted_ctrl[g]),
      .data_o    (voted_data[g]),
      .error_o   (tmr_error_o[g]),
      .failure_o (tmr_failure_o[g])
    );

    hmr_mode_fsm i_mode_fsm (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .error_i             (tmr_error_o[g]),
      .failure_i           (tmr_failure_o[g]),
      .fetch_en_i          (sys_in_i[g].fetch_en),
      .busy_i              (core_ctrl_i[g].busy),
      .cores_synch_i       (tmr_cores_synch_i[g]),
      .independent_i       (independent[g]),
      .setback_en_i        (setback_en[g]),
      .reload_setback_en_i (reload_setback_en[g]),
      .force_resynch_i     (force_resynch[g]),
      .sp_store_i          (sp_store[g]),
      .mode_o              (mode[g]),
      .count_o             (count[g]),
      .force_clr_o         (force_clr[g]),
      .setback_o           (setback[g])
    );

    assign core_setback_o[g]       = setback[g];
    assign core_setback_o[g+G]     = setback[g];
    assign core_setback_o[g+2*G]   = setback[g];
  end

  hmr_cfg_regs i_cfg_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .cfg_we_i            (cfg_we_i),
    .cfg_addr_i          (cfg_addr_i),
    .cfg_wdata_i         (cfg_wdata_i),
    .cfg_rdata_o         (cfg_rdata_o),
    .mode_i              (mode),
    .count_i             (count),
    .force_clr_i         (force_clr),
    .independent_o       (independent),
    .setback_en_o        (setback_en),
    .reload_setback_en_o (reload_setback_en),
    .force_resynch_o     (force_resynch),
    .sp_store_o          (sp_store)
  );

  hmr_core_mux i_core_mux (
    .mode_i       (mode),
    .sys_in_i     (sys_in_i),
    .core_ctrl_i  (core_ctrl_i),
    .core_data_i  (core_data_i),
    .voted_ctrl_i (voted_ctrl),
    .voted_data_i (voted_data),
    .core_in_o    (core_in_o),
    .sys_ctrl_o   (sys_ctrl_o),
    .sys_data_o   (sys_data_o)
  );

endmodule

/* tb_hmr_wrap.sv */
// Directed testbench for the TMR wrapper with one group, compare tasks and an LCG
`include "hmr_settings.svh"

module tb_hmr_wrap;
  timeunit 1ns;
  timeprecision 100ps;

  import hmr_pkg::*;

  localparam int unsigned N = `HMR_NUM_CORES;
  localparam int unsigned G = `HMR_NUM_GROUPS;
  localparam int unsigned WaitCycles = 20;

  logic                 clk;
  logic                 rst_n;
  logic                 cfg_we;
  cfg_addr_t            cfg_addr;
  word_t                cfg_wdata;
  word_t                cfg_rdata;
  logic       [G-1:0]   cores_synch;
  vote_err_t  [G-1:0]   tmr_error;
  logic       [G-1:0]   tmr_failure;
  sys_in_t    [N-1:0]   sys_in;
  core_ctrl_t [N-1:0]   core_ctrl;
  core_data_t [N-1:0]   core_data;
  sys_in_t    [N-1:0]   core_in;
  core_ctrl_t [N-1:0]   sys_ctrl;
  core_data_t [N-1:0]   sys_data;
  logic       [N-1:0]   core_setback;

  int unsigned err_cnt = 0;
  int unsigned timeout_cnt = 0;
  int unsigned exp_cnt [3] = '{0, 0, 0};
  logic [31:0] seed = 32'd25;

  hmr_wrap DUT (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .cfg_we_i          (cfg_we),
    .cfg_addr_i        (cfg_addr),
    .cfg_wdata_i       (cfg_wdata),
    .cfg_rdata_o       (cfg_rdata),
    .tmr_cores_synch_i (cores_synch),
    .tmr_error_o       (tmr_error),
    .tmr_failure_o     (tmr_failure),
    .sys_in_i          (sys_in),
    .core_ctrl_i       (core_ctrl),
    .core_data_i       (core_data),
    .core_in_o         (core_in),
    .sys_ctrl_o        (sys_ctrl),
    .sys_data_o        (sys_data),
    .core_setback_o    (core_setback)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // Upper LCG bits, the low ones repeat quickly
  function automatic int unsigned pick(input int unsigned range);
    return (next_rand() >> 16) % range;
  endfunction

  function automatic core_ctrl_t rand_ctrl();
    core_ctrl_t c;
    logic [31:0] r;
    r = next_rand();
    c.busy = r[18];
    c.instr_req = r[22];
    c.data_req = r[26];
    c.instr_addr = next_rand();
    return c;
  endfunction

  function automatic core_data_t rand_data();
    core_data_t d;
    logic [31:0] r;
    r = next_rand();
    d.data_we = r[20];
    d.data_be = r[27:24];
    d.data_addr = next_rand();
    d.data_wdata = next_rand();
    return d;
  endfunction

  // Fetch stays enabled so idle cores do not restart the mode
  function automatic sys_in_t rand_sys_in();
    sys_in_t s;
    logic [31:0] r;
    r = next_rand();
    s.fetch_en = 1'b1;
    s.instr_gnt = r[18];
    s.instr_rvalid = r[21];
    s.data_gnt = r[24];
    s.data_rvalid = r[27];
    s.boot_addr = next_rand();
    s.instr_rdata = next_rand();
    s.data_rdata = next_rand();
    return s;
  endfunction

  task automatic check_ctrl(input string name, input core_ctrl_t act, input core_ctrl_t exp);
    if (act !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_data(input string name, input core_data_t act, input core_data_t exp);
    if (act !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_sys_in(input string name, input sys_in_t act, input sys_in_t exp);
    if (act !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_err(input string name, input vote_err_t act, input vote_err_t exp);
    if (act !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic set_idle();
    sys_in = '0;
    core_ctrl = '0;
    core_data = '0;
  endtask

  task automatic write_reg(input int unsigned reg_idx, input word_t data);
    @(negedge clk);
    cfg_we = 1'b1;
    cfg_addr = cfg_addr_t'(reg_idx);
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic read_reg(input int unsigned reg_idx, output word_t data);
    @(negedge clk);
    cfg_addr = cfg_addr_t'(reg_idx);
    #2;
    data = cfg_rdata;
  endtask

  task automatic wait_status(input tmr_mode_e exp_mode);
    int unsigned cycles;
    logic        reached;
    cycles = 0;
    reached = 1'b0;
    while (!reached && cycles < WaitCycles) begin
      @(negedge clk);
      cfg_addr = cfg_addr_t'(`HMR_REG_STATUS);
      #2;
      reached = (cfg_rdata == word_t'(exp_mode));
      cycles++;
    end
    if (!reached) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: status never reached %s", $time, exp_mode.name());
    end
  endtask

  task automatic check_counters();
    word_t rd;
    for (int k = 0; k < 3; k++) begin
      read_reg(`HMR_REG_MISMATCH0 + k, rd);
      check_word($sformatf("mismatch counter %0d", k), rd, word_t'(exp_cnt[k]));
    end
  endtask

  task automatic test_reset();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    cfg_addr = cfg_addr_t'(`HMR_REG_STATUS);
    #2;
    check_word("status after reset", cfg_rdata, word_t'(NON_TMR));
    check_word("core_setback_o", word_t'(core_setback), '0);
    // Idle cores move to RUN at the first edge
    @(negedge clk);
    #2;
    check_word("status one cycle after reset", cfg_rdata, word_t'(TMR_RUN));
    check_counters();
  endtask

  task automatic test_voting();
    core_ctrl_t  base_ctrl;
    core_data_t  base_data;
    int unsigned bad;
    int unsigned other;
    int unsigned bit_pos;
    base_ctrl = rand_ctrl();
    base_data = rand_data();
    bad = pick(3);
    bit_pos = pick($bits(core_ctrl_t));
    @(negedge clk);
    for (int i = 0; i < N; i++) begin
      sys_in[i] = rand_sys_in();
      core_ctrl[i] = base_ctrl;
      core_data[i] = base_data;
    end
    core_ctrl[bad] = core_ctrl_t'(base_ctrl ^ (core_ctrl_t'(1) << bit_pos));
    #2;
    check_ctrl("sys_ctrl_o[0]", sys_ctrl[0], base_ctrl);
    check_data("sys_data_o[0]", sys_data[0], base_data);
    check_err("tmr_error_o", tmr_error[0], vote_err_t'(1 << bad));
    check_flag("tmr_failure_o", tmr_failure[0], 1'b0);
    for (int i = 1; i < N; i++) begin
      check_ctrl($sformatf("sys_ctrl_o[%0d]", i), sys_ctrl[i], '0);
      check_data($sformatf("sys_data_o[%0d]", i), sys_data[i], '0);
    end
    for (int i = 0; i < N; i++) begin
      check_sys_in($sformatf("core_in_o[%0d]", i), core_in[i], sys_in[0]);
    end
    // Mismatch in RUN counts once, then the group sits in UNLOAD
    exp_cnt[bad]++;
    @(negedge clk);
    cfg_addr = cfg_addr_t'(`HMR_REG_STATUS);
    base_ctrl.data_req = 1'b0;
    for (int i = 0; i < N; i++) begin
      core_ctrl[i] = base_ctrl;
      core_data[i] = base_data;
    end
    core_data[bad] = core_data_t'(base_data ^ (core_data_t'(1) << bit_pos));
    #2;
    check_err("tmr_error_o with data_req low", tmr_error[0], '0);
    check_flag("tmr_failure_o with data_req low", tmr_failure[0], 1'b0);
    check_word("status after voting mismatch", cfg_rdata, word_t'(TMR_UNLOAD));
    // Two replicas off in different bits, only the third one is clean
    @(negedge clk);
    other = (bad + 1) % 3;
    core_data[bad] = base_data;
    core_ctrl[bad] = core_ctrl_t'(base_ctrl ^ (core_ctrl_t'(1) << bit_pos));
    core_ctrl[other] = core_ctrl_t'(base_ctrl ^
                       (core_ctrl_t'(1) << ((bit_pos + 1) % $bits(core_ctrl_t))));
    #2;
    check_ctrl("sys_ctrl_o[0] with two bad cores", sys_ctrl[0], base_ctrl);
    check_err("tmr_error_o with two bad cores", tmr_error[0],
              vote_err_t'((1 << bad) | (1 << other)));
    check_flag("tmr_failure_o with two bad cores", tmr_failure[0], 1'b1);
    @(negedge clk);
    set_idle();
    wait_status(TMR_RUN);
  endtask

  task automatic test_resynch();
    core_ctrl_t  base_ctrl;
    int unsigned bad;
    int unsigned cycles;
    logic        seen;
    word_t       sp_val;
    write_reg(`HMR_REG_MODE, 32'h2);
    base_ctrl = rand_ctrl();
    bad = pick(3);
    @(negedge clk);
    for (int i = 0; i < N; i++) begin
      sys_in[i] = rand_sys_in();
      core_ctrl[i] = base_ctrl;
      core_data[i] = '0;
    end
    core_ctrl[bad].instr_addr = ~base_ctrl.instr_addr;
    exp_cnt[bad]++;
    @(negedge clk);
    core_ctrl[bad] = base_ctrl;
    wait_status(TMR_UNLOAD);
    check_counters();
    sp_val = next_rand() | 32'h1;
    write_reg(`HMR_REG_SP_STORE, sp_val);
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < WaitCycles) begin
      @(negedge clk);
      cfg_addr = cfg_addr_t'(`HMR_REG_STATUS);
      #2;
      seen = (core_setback != '0);
      cycles++;
    end
    if (!seen) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: setback pulse never appeared", $time);
    end else begin
      check_word("core_setback_o", word_t'(core_setback), word_t'({N{1'b1}}));
      check_word("status during setback", cfg_rdata, word_t'(TMR_RELOAD));
      @(negedge clk);
      #2;
      check_word("core_setback_o after pulse", word_t'(core_setback), '0);
    end
    write_reg(`HMR_REG_SP_STORE, '0);
    wait_status(TMR_RUN);
  endtask

  task automatic test_force_resynch();
    word_t rd;
    write_reg(`HMR_REG_MODE, 32'h8);
    wait_status(TMR_UNLOAD);
    read_reg(`HMR_REG_MODE, rd);
    check_word("mode register after force resynch", rd, '0);
    @(negedge clk);
    set_idle();
    wait_status(TMR_RUN);
  endtask

  task automatic test_independent();
    word_t rd;
    write_reg(`HMR_REG_MODE, 32'h1);
    wait_status(NON_TMR);
    @(negedge clk);
    for (int i = 0; i < N; i++) begin
      sys_in[i] = rand_sys_in();
      core_ctrl[i] = rand_ctrl();
      core_data[i] = rand_data();
    end
    #2;
    for (int i = 0; i < N; i++) begin
      check_ctrl($sformatf("sys_ctrl_o[%0d]", i), sys_ctrl[i], core_ctrl[i]);
      check_data($sformatf("sys_data_o[%0d]", i), sys_data[i], core_data[i]);
      check_sys_in($sformatf("core_in_o[%0d]", i), core_in[i], sys_in[i]);
    end
    @(negedge clk);
    core_ctrl = '0;
    core_data = '0;
    write_reg(`HMR_REG_MODE, '0);
    // Still split until the cores report they are in step
    read_reg(`HMR_REG_STATUS, rd);
    check_word("status before cores_synch", rd, word_t'(NON_TMR));
    @(negedge clk);
    cores_synch = '1;
    @(negedge clk);
    cores_synch = '0;
    wait_status(TMR_RUN);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    cores_synch = '0;
    set_idle();
    test_reset();
    test_voting();
    test_resynch();
    test_force_resynch();
    test_independent();
    $display("Finished with %0d value errors and %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    #50000;
    $display("Simulation ran out of time before all tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
